// ==== src.f ====
hdl/etx_pkg.sv
hdl/etx_link_if.sv
hdl/etx_fifo.sv
hdl/etx_cfg.sv
hdl/etx_arbiter.sv
hdl/etx_io.sv
hdl/etx_top.sv
test/etx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the transmit link testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module etx_tb -f src.f -o etx_sim \
  && ./obj_dir/etx_sim | tee /dev/stderr | grep -q "=== PASS ===" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== test/etx_tb.sv ====
// Testbench with clock, reset, random channel traffic, model queues, frame reassembly and compares
module etx_tb
  import etx_pkg::*;
();

  logic       clk;
  logic       reset;
  logic       wr_access;
  packet_t    wr_packet;
  logic       wr_wait;
  logic       rd_access;
  packet_t    rd_packet;
  logic       rd_wait;
  logic       rr_access;
  packet_t    rr_packet;
  logic       rr_wait;
  logic       cfg_write;
  cfg_addr_e  cfg_addr;
  logic [7:0] cfg_wdata;
  logic [7:0] cfg_rdata;
  logic       tx_frame;
  logic [7:0] tx_data;
  logic       tx_wr_wait;
  logic       tx_rd_wait;

  // Expected packets per channel, in push order
  packet_t     wr_q[$];
  packet_t     rd_q[$];
  packet_t     rr_q[$];
  // Header kinds in arrival order
  frame_kind_e kind_log[$];

  frame_kind_e       channels[3] = '{FK_WRITE, FK_READ, FK_RESP};
  logic              model_bypass;
  logic [CTRL_W-1:0] model_mode;
  int                frames_seen;
  int                errors;
  int                count_errors;
  int                test_start_errors;
  int                tests_run;
  int                tests_failed;
  logic              stop_waits;

  // Frame reassembly state
  logic [7:0] head_byte;
  packet_t    rx_packet;
  int         beat_count;

  etx_top etx_top_i (
    .clk(clk), .reset(reset),
    .wr_access(wr_access), .wr_packet(wr_packet), .wr_wait(wr_wait),
    .rd_access(rd_access), .rd_packet(rd_packet), .rd_wait(rd_wait),
    .rr_access(rr_access), .rr_packet(rr_packet), .rr_wait(rr_wait),
    .cfg_write(cfg_write), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
    .tx_frame(tx_frame), .tx_data(tx_data),
    .tx_wr_wait(tx_wr_wait), .tx_rd_wait(tx_rd_wait)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ############################################################
  // Model and compares
  // ############################################################

  // Writes carry bit 1 set, read requests clear, responses random
  function automatic packet_t random_packet(input frame_kind_e ch);
    logic [127:0] raw;
    packet_t      p;
    raw = {$urandom(), $urandom(), $urandom(), $urandom()};
    p = raw[PW-1:0];
    if (ch == FK_WRITE)
      p[WRITE_BIT] = 1'b1;
    else if (ch == FK_READ)
      p[WRITE_BIT] = 1'b0;
    return p;
  endfunction

  // Control-mode override applies to writes and read requests only
  task automatic expect_push(input frame_kind_e ch, input packet_t p);
    packet_t e;
    e = p;
    if (model_bypass && ch != FK_RESP)
      e[CTRL_LSB +: CTRL_W] = model_mode;
    case (ch)
      FK_WRITE: wr_q.push_back(e);
      FK_READ:  rd_q.push_back(e);
      default:  rr_q.push_back(e);
    endcase
  endtask

  task automatic compare_packet(input packet_t actual, input packet_t expected, input string what);
    if (actual !== expected)
    begin
      $display("Fail %0t: %s packet %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic compare_kind(input frame_kind_e actual, input frame_kind_e expected);
    if (actual !== expected)
    begin
      $display("Fail %0t: header %s, expected %s", $time, actual.name(), expected.name());
      errors++;
    end
  endtask

  task automatic compare_count(input logic [7:0] actual, input logic [7:0] expected);
    if (actual !== expected)
    begin
      $display("Fail %0t: frame count %0d, expected %0d", $time, actual, expected);
      errors++;
      count_errors++;
    end
  endtask

  // Closes a frame at the falling tx_frame
  task automatic finish_frame();
    frame_kind_e kind;
    packet_t     expected;
    logic        found;
    frames_seen++;
    found = 1'b0;
    kind = frame_kind_e'(head_byte);
    if (beat_count != BEATS + 1)
    begin
      $display("Fail %0t: frame of %0d beats, expected %0d", $time, beat_count, BEATS + 1);
      errors++;
    end
    // Header picks the channel queue
    case (head_byte)
      FK_WRITE:
        if (wr_q.size() > 0)
        begin
          expected = wr_q.pop_front();
          found    = 1'b1;
        end
      FK_READ:
        if (rd_q.size() > 0)
        begin
          expected = rd_q.pop_front();
          found    = 1'b1;
        end
      FK_RESP:
        if (rr_q.size() > 0)
        begin
          expected = rr_q.pop_front();
          found    = 1'b1;
        end
      default: ;
    endcase
    if (!found)
    begin
      $display("Frame at %0t with header %h matches no waiting packet", $time, head_byte);
      errors++;
    end
    else
    begin
      compare_packet(rx_packet, expected, kind.name());
      kind_log.push_back(kind);
    end
  endtask

  // Monitor samples pins at the falling clock, away from the updates
  always @(negedge clk)
  begin
    if (reset)
      beat_count = 0;
    else if (tx_frame)
    begin
      if (beat_count == 0)
        head_byte = tx_data;
      else if (beat_count <= BEATS)
        rx_packet[(beat_count - 1) * 8 +: 8] = tx_data;
      beat_count++;
    end
    else if (beat_count != 0)
    begin
      finish_frame();
      beat_count = 0;
    end
  end

  // ############################################################
  // Drivers
  // ############################################################

  task automatic drive_channel(input frame_kind_e ch, input logic access, input packet_t p);
    case (ch)
      FK_WRITE:
      begin
        wr_access = access;
        wr_packet = p;
      end
      FK_READ:
      begin
        rd_access = access;
        rd_packet = p;
      end
      default:
      begin
        rr_access = access;
        rr_packet = p;
      end
    endcase
  endtask

  function automatic logic channel_wait(input frame_kind_e ch);
    case (ch)
      FK_WRITE: return wr_wait;
      FK_READ:  return rd_wait;
      default:  return rr_wait;
    endcase
  endfunction

  // Holds access until the FIFO takes the packet or the limit runs out
  task automatic push_packet(input frame_kind_e ch, input packet_t p, input int limit,
                             output logic accepted);
    int waited;
    waited = 0;
    accepted = 1'b0;
    drive_channel(ch, 1'b1, p);
    while (!accepted && waited < limit)
    begin
      @(negedge clk);
      accepted = !channel_wait(ch);
      @(posedge clk);
      #1;
      waited++;
    end
    drive_channel(ch, 1'b0, p);
    if (accepted)
      expect_push(ch, p);
  endtask

  // Low priority channels may starve behind two full bursts
  task automatic send_packet(input frame_kind_e ch);
    logic accepted;
    push_packet(ch, random_packet(ch), 2000, accepted);
    if (!accepted)
    begin
      $display("Timeout at %0t: %s channel stayed full", $time, ch.name());
      errors++;
    end
  endtask

  task automatic send_burst(input frame_kind_e ch, input int n);
    for (int i = 0; i < n; i++)
    begin
      repeat ($urandom_range(3, 0))
      begin
        @(posedge clk);
        #1;
      end
      send_packet(ch);
    end
  endtask

  // Random remote stalls until the bursts finish
  task automatic drive_remote_waits();
    int cycles;
    cycles = 0;
    while (!stop_waits && cycles < 20000)
    begin
      tx_wr_wait = ($urandom_range(3, 0) == 0);
      tx_rd_wait = ($urandom_range(3, 0) == 0);
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!stop_waits)
    begin
      $display("Timeout at %0t: random traffic bursts never finished", $time);
      errors++;
    end
    tx_wr_wait = 1'b0;
    tx_rd_wait = 1'b0;
  endtask

  // Queues and frame state are settled at the falling edge
  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while ((wr_q.size() + rd_q.size() + rr_q.size() != 0 || tx_frame || beat_count != 0)
           && waited < 5000)
    begin
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    #1;
    if (waited >= 5000)
    begin
      $display("Timeout at %0t: %s left %0d packets unsent", $time, what,
               wr_q.size() + rd_q.size() + rr_q.size());
      errors++;
    end
  endtask

  task automatic write_reg(input cfg_addr_e addr, input logic [7:0] data);
    cfg_write = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_write = 1'b0;
  endtask

  task automatic set_config(input logic enable, input logic bypass, input logic [3:0] mode);
    write_reg(REG_CTRLMODE, {4'b0, mode});
    write_reg(REG_CTRL, {6'b0, bypass, enable});
    model_bypass = bypass;
    model_mode   = mode;
  endtask

  // Frame counter against frames seen on the pins
  task automatic check_count();
    logic [7:0] value;
    cfg_addr = REG_COUNT;
    @(negedge clk);
    value = cfg_rdata;
    @(posedge clk);
    #1;
    compare_count(value, 8'(frames_seen));
  endtask

  task automatic end_test(input string name);
    check_count();
    tests_run++;
    if (errors == test_start_errors)
      $display("Test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // ############################################################
  // Test sequence
  // ############################################################

  initial
  begin
    logic              accepted;
    int                accepted_count;
    logic [CTRL_W-1:0] mode;
    frame_kind_e       want;
    void'($urandom(24942));
    reset = 1'b1;
    wr_access = 1'b0;
    wr_packet = '0;
    rd_access = 1'b0;
    rd_packet = '0;
    rr_access = 1'b0;
    rr_packet = '0;
    cfg_write = 1'b0;
    cfg_addr = REG_COUNT;
    cfg_wdata = 8'h00;
    tx_wr_wait = 1'b0;
    tx_rd_wait = 1'b0;
    model_bypass = 1'b0;
    model_mode = '0;
    frames_seen = 0;
    errors = 0;
    count_errors = 0;
    test_start_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    stop_waits = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Disabled link, each FIFO fills and raises its wait
    set_config(1'b0, 1'b0, 4'h0);
    foreach (channels[c])
    begin
      accepted_count = 0;
      for (int i = 0; i < FIFO_DEPTH + 2; i++)
      begin
        push_packet(channels[c], random_packet(channels[c]), 1, accepted);
        if (accepted)
          accepted_count++;
      end
      if (accepted_count != FIFO_DEPTH)
      begin
        $display("Fail %0t: %s FIFO took %0d packets, expected %0d", $time,
                 channels[c].name(), accepted_count, FIFO_DEPTH);
        errors++;
      end
    end
    repeat (30)
    begin
      @(negedge clk);
      if (tx_frame)
      begin
        $display("Frame started at %0t while transmit was disabled", $time);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    end_test("enable off");

    // Full FIFOs drain by priority once enabled
    kind_log.delete();
    set_config(1'b1, 1'b0, 4'h0);
    wait_drain("priority drain");
    if (kind_log.size() != 3 * FIFO_DEPTH)
    begin
      $display("Fail %0t: %0d frames in priority drain, expected %0d", $time,
               kind_log.size(), 3 * FIFO_DEPTH);
      errors++;
    end
    foreach (kind_log[i])
    begin
      want = channels[i / FIFO_DEPTH];
      compare_kind(kind_log[i], want);
    end
    end_test("priority");

    // Override on, then off
    mode = $urandom_range(15, 0);
    set_config(1'b1, 1'b1, mode);
    for (int i = 0; i < 3; i++)
      foreach (channels[c])
        send_packet(channels[c]);
    wait_drain("override on");
    set_config(1'b1, 1'b0, mode);
    for (int i = 0; i < 3; i++)
      foreach (channels[c])
        send_packet(channels[c]);
    wait_drain("override off");
    end_test("control-mode override");

    // Concurrent traffic against random remote stalls
    stop_waits = 1'b0;
    fork
      begin
        fork
          send_burst(FK_WRITE, 20);
          send_burst(FK_READ, 20);
          send_burst(FK_RESP, 20);
        join
        stop_waits = 1'b1;
      end
      drive_remote_waits();
    join
    wait_drain("random traffic");
    end_test("random traffic");

    // Counter was read back after every test
    tests_run++;
    if (count_errors == 0)
      $display("Test %0d frame counter: ok", tests_run);
    else
    begin
      tests_failed++;
      $display("Test %0d frame counter: failed with %0d errors", tests_run, count_errors);
    end

    $display("Tests run %0d, failed %0d, errors %0d, frames %0d", tests_run, tests_failed,
             errors, frames_seen);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== hdl/etx_top.sv ====
// Transmit top level with channel FIFOs, register block, arbiter and pin stage
module etx_top
  import etx_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  // Host channels
  input  logic       wr_access,
  input  packet_t    wr_packet,
  output logic       wr_wait,
  input  logic       rd_access,
  input  packet_t    rd_packet,
  output logic       rd_wait,
  input  logic       rr_access,
  input  packet_t    rr_packet,
  output logic       rr_wait,
  // Register port
  input  logic       cfg_write,
  input  cfg_addr_e  cfg_addr,
  input  logic [7:0] cfg_wdata,
  output logic [7:0] cfg_rdata,
  // Pins
  output logic       tx_frame,
  output logic [7:0] tx_data,
  input  logic       tx_wr_wait,
  input  logic       tx_rd_wait
);

  logic              wr_fifo_access;
  logic              rd_fifo_access;
  logic              rr_fifo_access;
  packet_t           wr_fifo_packet;
  packet_t           rd_fifo_packet;
  packet_t           rr_fifo_packet;
  logic              wr_pop;
  logic              rd_pop;
  logic              rr_pop;
  logic              ctrlmode_bypass;
  logic [CTRL_W-1:0] ctrlmode;
  logic              cfg_wait;
  logic              frame_done;

  etx_link_if link ();

  // One FIFO per channel
  etx_fifo wr_fifo (
    .clk(clk), .reset(reset),
    .in_access(wr_access), .in_packet(wr_packet), .in_wait(wr_wait),
    .out_access(wr_fifo_access), .out_packet(wr_fifo_packet), .pop(wr_pop)
  );

  etx_fifo rd_fifo (
    .clk(clk), .reset(reset),
    .in_access(rd_access), .in_packet(rd_packet), .in_wait(rd_wait),
    .out_access(rd_fifo_access), .out_packet(rd_fifo_packet), .pop(rd_pop)
  );

  etx_fifo rr_fifo (
    .clk(clk), .reset(reset),
    .in_access(rr_access), .in_packet(rr_packet), .in_wait(rr_wait),
    .out_access(rr_fifo_access), .out_packet(rr_fifo_packet), .pop(rr_pop)
  );

  etx_cfg cfg_i (
    .clk(clk), .reset(reset),
    .cfg_write(cfg_write), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
    .frame_done(frame_done),
    .ctrlmode_bypass(ctrlmode_bypass), .ctrlmode(ctrlmode), .cfg_wait(cfg_wait)
  );

  etx_arbiter arbiter_i (
    .clk(clk), .reset(reset),
    .wr_access(wr_fifo_access), .rd_access(rd_fifo_access), .rr_access(rr_fifo_access),
    .wr_packet(wr_fifo_packet), .rd_packet(rd_fifo_packet), .rr_packet(rr_fifo_packet),
    .wr_pop(wr_pop), .rd_pop(rd_pop), .rr_pop(rr_pop),
    .ctrlmode_bypass(ctrlmode_bypass), .ctrlmode(ctrlmode), .cfg_wait(cfg_wait),
    .link(link.src)
  );

  etx_io io_i (
    .clk(clk), .reset(reset),
    .link(link.dst),
    .tx_wr_wait(tx_wr_wait), .tx_rd_wait(tx_rd_wait),
    .tx_frame(tx_frame), .tx_data(tx_data), .frame_done(frame_done)
  );

endmodule

// ==== hdl/etx_io.sv ====
// Pin stage FSM sending a header byte and thirteen data bytes per packet
module etx_io
  import etx_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  etx_link_if.dst    link,
  input  logic       tx_wr_wait,
  input  logic       tx_rd_wait,
  output logic       tx_frame,
  output logic [7:0] tx_data,
  output logic       frame_done
);

  io_state_e         state_q;
  logic [BEAT_W-1:0] beat_q;
  packet_t           shift_q;
  frame_kind_e       kind_q;
  logic              held_wait;
  logic              take;
  logic              last_beat;

  // Busy or remote stall holds the arbiter off
  assign link.wr_wait = (state_q != IO_IDLE) || tx_wr_wait;
  assign link.rd_wait = (state_q != IO_IDLE) || tx_rd_wait;

  // Low class wait means idle and remote ready
  assign held_wait = uses_wr_wait(link.rr, link.packet) ? link.wr_wait : link.rd_wait;
  assign take      = link.access && (state_q == IO_IDLE) && !held_wait;
  assign last_beat = (state_q == IO_DATA) && (beat_q == BEAT_W'(BEATS - 1));

  // ############################################################
  // State and beat counter
  // ############################################################

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= IO_IDLE;
      beat_q  <= '0;
    end
    else
    begin
      case (state_q)
        IO_IDLE:
          if (take)
            state_q <= IO_HEAD;
        IO_HEAD:
        begin
          state_q <= IO_DATA;
          beat_q  <= '0;
        end
        IO_DATA:
        begin
          beat_q <= beat_q + 1'b1;
          if (last_beat)
            state_q <= IO_IDLE;
        end
        default: state_q <= IO_IDLE;
      endcase
    end
  end

  // Packet shifter and header kind, least significant byte leaves first
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      shift_q <= link.packet;
      if (link.rr)
        kind_q <= FK_RESP;
      else if (link.packet[WRITE_BIT])
        kind_q <= FK_WRITE;
      else
        kind_q <= FK_READ;
    end
    else if (state_q == IO_DATA)
      shift_q <= shift_q >> 8;
  end

  // ############################################################
  // Pins
  // ############################################################

  assign tx_frame   = (state_q != IO_IDLE);
  assign frame_done = last_beat;

  always_comb
  begin
    case (state_q)
      IO_HEAD: tx_data = kind_q;
      IO_DATA: tx_data = shift_q[7:0];
      default: tx_data = 8'h00;
    endcase
  end

  // Frame is header plus BEATS data bytes, then tx_frame drops
  assert property (@(posedge clk) disable iff (reset) $rose(tx_frame) |-> ##(BEATS) frame_done);
  assert property (@(posedge clk) disable iff (reset) frame_done |=> !tx_frame);
  assert property (@(posedge clk) disable iff (reset) $fell(tx_frame) |-> $past(frame_done));

endmodule

// ==== hdl/etx_arbiter.sv ====
// Fixed-priority channel arbiter with control-mode insertion and a registered link stage
module etx_arbiter
  import etx_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wr_access,
  input  logic              rd_access,
  input  logic              rr_access,
  input  packet_t           wr_packet,
  input  packet_t           rd_packet,
  input  packet_t           rr_packet,
  output logic              wr_pop,
  output logic              rd_pop,
  output logic              rr_pop,
  input  logic              ctrlmode_bypass,
  input  logic [CTRL_W-1:0] ctrlmode,
  input  logic              cfg_wait,
  etx_link_if.src           link
);

  // Overwrite the control-mode field when bypass is set
  function automatic packet_t insert_ctrlmode(
    input packet_t           packet,
    input logic              bypass,
    input logic [CTRL_W-1:0] mode
  );
    packet_t result;
    result = packet;
    if (bypass)
      result[CTRL_LSB +: CTRL_W] = mode;
    return result;
  endfunction

  // ############################################################
  // Grants, write first, then read request, then response
  // ############################################################

  logic    wr_grant;
  logic    rd_grant;
  logic    rr_grant;
  logic    wr_ok;
  logic    rd_ok;
  logic    take_in;
  logic    held_wait;
  logic    taken;
  logic    reg_free;
  logic    load;
  packet_t mux_packet;

  assign wr_grant = wr_access;
  assign rd_grant = rd_access && !wr_access;
  assign rr_grant = rr_access && !wr_access && !rd_access;

  // Per-class go, responses ride on the write wait
  assign wr_ok = !cfg_wait && !link.wr_wait;
  assign rd_ok = !cfg_wait && !link.rd_wait;

  assign take_in = (wr_grant && wr_ok) || (rd_grant && rd_ok) || (rr_grant && wr_ok);

  // Pin stage takes the held packet when its class wait is low
  assign held_wait = uses_wr_wait(link.rr, link.packet) ? link.wr_wait : link.rd_wait;
  assign taken     = link.access && !held_wait;
  assign reg_free  = !link.access || taken;
  assign load      = take_in && reg_free;

  assign wr_pop = wr_grant && wr_ok && reg_free;
  assign rd_pop = rd_grant && rd_ok && reg_free;
  assign rr_pop = rr_grant && wr_ok && reg_free;

  // Priority mux, responses pass unchanged
  always_comb
  begin
    if (wr_grant)
      mux_packet = insert_ctrlmode(wr_packet, ctrlmode_bypass, ctrlmode);
    else if (rd_grant)
      mux_packet = insert_ctrlmode(rd_packet, ctrlmode_bypass, ctrlmode);
    else
      mux_packet = rr_packet;
  end

  // ############################################################
  // Output register
  // ############################################################

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      link.access <= 1'b0;
      link.rr     <= 1'b0;
    end
    else if (load)
    begin
      link.access <= 1'b1;
      link.rr     <= rr_grant;
    end
    else if (taken)
      link.access <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      link.packet <= mux_packet;
  end

  // At most one channel popped per cycle
  assert property (@(posedge clk) disable iff (reset) $onehot0({wr_pop, rd_pop, rr_pop}));
  // A held packet stays put until the pin stage takes it
  assert property (@(posedge clk) disable iff (reset)
    (link.access && !taken) |=> (link.access && $stable(link.packet) && $stable(link.rr)));

endmodule

// ==== hdl/etx_cfg.sv ====
// Control, control-mode and frame-count registers with combinational read decode
module etx_cfg
  import etx_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              cfg_write,
  input  cfg_addr_e         cfg_addr,
  input  logic [7:0]        cfg_wdata,
  output logic [7:0]        cfg_rdata,
  input  logic              frame_done,
  output logic              ctrlmode_bypass,
  output logic [CTRL_W-1:0] ctrlmode,
  output logic              cfg_wait
);

  // ############################################################
  // Registers
  // ############################################################

  logic              enable;
  logic              bypass;
  logic [CTRL_W-1:0] mode;
  logic [7:0]        frame_count;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      enable <= 1'b0;
      bypass <= 1'b0;
      mode   <= '0;
    end
    else if (cfg_write)
    begin
      case (cfg_addr)
        REG_CTRL:
        begin
          enable <= cfg_wdata[0];
          bypass <= cfg_wdata[1];
        end
        REG_CTRLMODE:
          mode <= cfg_wdata[CTRL_W-1:0];
        // Count is read only
        default: ;
      endcase
    end
  end

  // Frame counter, wraps at 8 bits
  always_ff @(posedge clk)
  begin
    if (reset)
      frame_count <= '0;
    else if (frame_done)
      frame_count <= frame_count + 1'b1;
  end

  // ############################################################
  // Outputs
  // ############################################################

  // Hold the arbiter off while disabled
  assign cfg_wait        = !enable;
  assign ctrlmode_bypass = bypass;
  assign ctrlmode        = mode;

  always_comb
  begin
    case (cfg_addr)
      REG_CTRL:     cfg_rdata = {6'b0, bypass, enable};
      REG_CTRLMODE: cfg_rdata = {{(8 - CTRL_W){1'b0}}, mode};
      REG_COUNT:    cfg_rdata = frame_count;
      default:      cfg_rdata = 8'h00;
    endcase
  end

endmodule

// ==== hdl/etx_fifo.sv ====
// Per-channel packet FIFO with access/wait on the push side and access/pop on the pull side
module etx_fifo
  import etx_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    in_access,
  input  packet_t in_packet,
  output logic    in_wait,
  output logic    out_access,
  output packet_t out_packet,
  input  logic    pop
);

  // Storage, no reset needed on payload
  packet_t mem [FIFO_DEPTH];

  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count;
  logic               push;

  // Full doubles as the host wait
  assign in_wait    = (count == FIFO_CW'(FIFO_DEPTH));
  assign out_access = (count != '0);
  assign out_packet = mem[rd_ptr];
  assign push       = in_access && !in_wait;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_packet;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy never runs past the depth
  assert property (@(posedge clk) disable iff (reset) count <= FIFO_CW'(FIFO_DEPTH));
  // Arbiter only pops a non-empty FIFO
  assert property (@(posedge clk) disable iff (reset) pop |-> out_access);

endmodule

// ==== hdl/etx_link_if.sv ====
// Arbiter to pin stage link with packet, response flag and per-class waits
interface etx_link_if
  import etx_pkg::*;
();

  // Held packet, valid while access is high
  logic    access;
  packet_t packet;
  // Marks a read response
  logic    rr;

  // Waits back from the pin stage
  logic    wr_wait;
  logic    rd_wait;

  // Arbiter side
  modport src (
    output access, packet, rr,
    input  wr_wait, rd_wait
  );

  // Pin stage side
  modport dst (
    input  access, packet, rr,
    output wr_wait, rd_wait
  );

endinterface

// ==== hdl/etx_pkg.sv ====
// Shared packet layout, FIFO and frame constants, register map and state enums
package etx_pkg;

  // Packet and channel sizing
  localparam int PW         = 104;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

  // Data bytes per frame, header byte not included
  localparam int BEATS  = 13;
  localparam int BEAT_W = $clog2(BEATS);

  // Field positions inside a mesh packet
  localparam int WRITE_BIT = 1;
  localparam int CTRL_LSB  = 4;
  localparam int CTRL_W    = 4;

  typedef logic [PW-1:0] packet_t;

  // Header byte sent ahead of each frame
  typedef enum logic [7:0] {
    FK_WRITE = 8'h01,
    FK_READ  = 8'h02,
    FK_RESP  = 8'h03
  } frame_kind_e;

  // Pin stage states
  typedef enum logic [1:0] {
    IO_IDLE = 2'd0,
    IO_HEAD = 2'd1,
    IO_DATA = 2'd2
  } io_state_e;

  // Register map
  typedef enum logic [1:0] {
    REG_CTRL     = 2'd0,
    REG_CTRLMODE = 2'd1,
    REG_COUNT    = 2'd2
  } cfg_addr_e;

  // Writes and read responses share the write wait, read requests use the read wait
  function automatic logic uses_wr_wait(input logic rr, input packet_t packet);
    return rr || packet[WRITE_BIT];
  endfunction

endpackage
